//--- build.f
+incdir+design
design/commit_pkg.sv
design/alu_arbiter.sv
design/load_tracker.sv
design/commit_register.sv
design/commit_stage.sv
tb/commit_stage_tb.sv

//--- tb/commit_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_settings.svh"

module commit_stage_tb;

    logic clock, reset;
    logic alu1_valid, alu1_reg_write, alu1_mem_read, alu1_mem_write, alu1_taken;
    logic alu2_valid, alu2_reg_write, alu2_mem_read, alu2_mem_write, alu2_taken;
    commit_pkg::rd_t alu1_rd, alu2_rd;
    commit_pkg::data_t alu1_result, alu2_result, alu1_store_data, alu2_store_data;
    commit_pkg::inst_id_t alu1_id, alu2_id;
    commit_pkg::opcode_t alu1_opcode, alu2_opcode;
    commit_pkg::pc_sel_t alu1_pc_select, alu2_pc_select;
    commit_pkg::addr_t alu1_target, alu2_target;
    logic load_valid;
    commit_pkg::data_t load_data;
    logic mem_valid, mem_read, mem_write, commit_valid, reg_write, redirect_valid;
    commit_pkg::addr_t mem_address, redirect_target;
    commit_pkg::data_t mem_store_data, writeback_data;
    commit_pkg::inst_id_t commit_id;
    commit_pkg::rd_t writeback_rd;
    commit_pkg::pc_sel_t pc_select;
    integer seed;
    int error_count;

    localparam commit_pkg::opcode_t OP_ALU = 7'b0110011;
    localparam commit_pkg::opcode_t OP_LOAD = 7'b0000011;
    localparam commit_pkg::opcode_t OP_STORE = 7'b0100011;

    commit_stage DUT (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic drop_valids();
        alu1_valid = 1'b0;
        alu2_valid = 1'b0;
        load_valid = 1'b0;
    endtask

    task automatic drive_alu1(input commit_pkg::opcode_t opcode, input logic write_rd,
                              input logic read_mem, input logic write_mem, input logic taken);
        alu1_valid      = 1'b1;
        alu1_opcode     = opcode;
        alu1_reg_write  = write_rd;
        alu1_mem_read   = read_mem;
        alu1_mem_write  = write_mem;
        alu1_taken      = taken;
        alu1_rd         = $random(seed);
        alu1_result     = $random(seed);
        alu1_id         = $random(seed);
        alu1_pc_select  = $random(seed);
        alu1_target     = $random(seed);
        alu1_store_data = $random(seed);
    endtask

    // ALU2 only carries plain register-writing ALU ops here
    task automatic drive_alu2(input commit_pkg::opcode_t opcode);
        alu2_valid      = 1'b1;
        alu2_opcode     = opcode;
        alu2_reg_write  = 1'b1;
        alu2_mem_read   = 1'b0;
        alu2_mem_write  = 1'b0;
        alu2_taken      = 1'b0;
        alu2_rd         = $random(seed);
        alu2_result     = $random(seed);
        alu2_id         = $random(seed);
        alu2_pc_select  = $random(seed);
        alu2_target     = $random(seed);
        alu2_store_data = $random(seed);
    endtask

    task automatic check_commit(input commit_pkg::inst_id_t id, input commit_pkg::rd_t rd,
                                input commit_pkg::data_t data, input logic write_rd,
                                input logic redirect, input commit_pkg::addr_t target,
                                input commit_pkg::pc_sel_t select);
        check_value("commit_valid", commit_valid, 1);
        check_value("commit_id", commit_id, id);
        check_value("writeback_rd", writeback_rd, rd);
        check_value("writeback_data", writeback_data, data);
        check_value("reg_write", reg_write, write_rd);
        check_value("redirect_valid", redirect_valid, redirect);
        if (redirect) begin
            check_value("redirect_target", redirect_target, target);
            check_value("pc_select", pc_select, select);
        end
    endtask

    task automatic wait_commit(input int limit, output int cycles);
        cycles = 0;
        while (!commit_valid && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!commit_valid) begin
            $display("timeout: no commit seen within %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic single_alu_commit();
        drive_alu1(OP_ALU, 1'b1, 1'b0, 1'b0, 1'b0);
        #1;
        check_value("alu mem_valid", mem_valid, 0);
        next_cycle();
        drop_valids();
        check_commit(alu1_id, alu1_rd, alu1_result, 1'b1, 1'b0, alu1_target, alu1_pc_select);
        next_cycle();
        check_value("commit_valid after one cycle", commit_valid, 0);
    endtask

    task automatic alu_collision();
        drive_alu1(OP_ALU, 1'b1, 1'b0, 1'b0, 1'b0);
        drive_alu2(OP_ALU);
        next_cycle();
        drop_valids();
        check_commit(alu1_id, alu1_rd, alu1_result, 1'b1, 1'b0, alu1_target, alu1_pc_select);
        next_cycle();
        check_commit(alu2_id, alu2_rd, alu2_result, 1'b1, 1'b0, alu2_target, alu2_pc_select);
        next_cycle();
        check_value("commit_valid after collision", commit_valid, 0);
    endtask

    task automatic store_request();
        drive_alu1(OP_STORE, 1'b1, 1'b0, 1'b1, 1'b0);
        #1;
        check_value("store mem_valid", mem_valid, 1);
        check_value("store mem_write", mem_write, 1);
        check_value("store mem_read", mem_read, 0);
        check_value("store mem_address", mem_address, alu1_result[`COMMIT_ADDRESS_BITS-1:0]);
        check_value("store mem_store_data", mem_store_data, alu1_store_data);
        next_cycle();
        drop_valids();
        check_commit(alu1_id, alu1_rd, alu1_result, 1'b0, 1'b0, alu1_target, alu1_pc_select);
        next_cycle();
    endtask

    task automatic issue_load(output commit_pkg::rd_t rd, output commit_pkg::inst_id_t id);
        drive_alu1(OP_LOAD, 1'b1, 1'b1, 1'b0, 1'b0);
        rd = alu1_rd;
        id = alu1_id;
        #1;
        check_value("load mem_valid", mem_valid, 1);
        check_value("load mem_read", mem_read, 1);
        check_value("load mem_write", mem_write, 0);
        check_value("load mem_address", mem_address, alu1_result[`COMMIT_ADDRESS_BITS-1:0]);
        next_cycle();
        drop_valids();
    endtask

    task automatic load_commit();
        commit_pkg::rd_t rd;
        commit_pkg::inst_id_t id;
        int cycles;
        issue_load(rd, id);
        repeat (3) begin
            check_value("commit_valid while load pending", commit_valid, 0);
            next_cycle();
        end
        load_valid = 1'b1;
        load_data = $random(seed);
        next_cycle();
        drop_valids();
        wait_commit(4, cycles);
        check_value("load commit delay", cycles, 0);
        check_commit(id, rd, load_data, 1'b1, 1'b0, '0, '0);
        next_cycle();
    endtask

    // ALU result wins the commit slot and the load follows
    task automatic load_alu_conflict();
        commit_pkg::rd_t rd;
        commit_pkg::inst_id_t id;
        int cycles;
        issue_load(rd, id);
        next_cycle();
        load_valid = 1'b1;
        load_data = $random(seed);
        drive_alu1(OP_ALU, 1'b1, 1'b0, 1'b0, 1'b0);
        next_cycle();
        drop_valids();
        check_commit(alu1_id, alu1_rd, alu1_result, 1'b1, 1'b0, alu1_target, alu1_pc_select);
        next_cycle();
        wait_commit(4, cycles);
        check_value("load commit delay after conflict", cycles, 0);
        check_commit(id, rd, load_data, 1'b1, 1'b0, '0, '0);
        next_cycle();
    endtask

    task automatic redirect_case(input commit_pkg::opcode_t opcode, input logic taken,
                                 input logic redirect);
        drive_alu1(opcode, 1'b1, 1'b0, 1'b0, taken);
        next_cycle();
        drop_valids();
        check_commit(alu1_id, alu1_rd, alu1_result, 1'b1, redirect, alu1_target,
                     alu1_pc_select);
        next_cycle();
    endtask

    task automatic redirect_decode();
        redirect_case(`COMMIT_OPCODE_JALR, 1'b0, 1'b1);
        redirect_case(`COMMIT_OPCODE_BRANCH, 1'b1, 1'b1);
        redirect_case(`COMMIT_OPCODE_BRANCH, 1'b0, 1'b0);
        redirect_case(OP_ALU, 1'b1, 1'b0);
    endtask

    initial begin
        seed = 32'ha2e9_5fff;
        error_count = 0;
        reset = 1'b1;
        {alu1_valid, alu1_rd, alu1_result, alu1_id, alu1_opcode, alu1_pc_select} = '0;
        {alu1_reg_write, alu1_mem_read, alu1_mem_write, alu1_taken, alu1_target} = '0;
        {alu2_valid, alu2_rd, alu2_result, alu2_id, alu2_opcode, alu2_pc_select} = '0;
        {alu2_reg_write, alu2_mem_read, alu2_mem_write, alu2_taken, alu2_target} = '0;
        {alu1_store_data, alu2_store_data, load_valid, load_data} = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("commit_valid after reset", commit_valid, 0);
        check_value("reg_write after reset", reg_write, 0);
        check_value("redirect_valid after reset", redirect_valid, 0);
        check_value("mem_valid after reset", mem_valid, 0);
        check_value("load_return_valid after reset", DUT.u_load_tracker.load_return_valid, 0);
        check_value("hold entry after reset", DUT.u_alu_arbiter.hold_valid, 0);
        single_alu_commit();
        alu_collision();
        store_request();
        load_commit();
        load_alu_conflict();
        redirect_decode();
        $display("checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         alu1_valid,
    input  wire commit_pkg::rd_t        alu1_rd,
    input  wire commit_pkg::data_t      alu1_result,
    input  wire commit_pkg::inst_id_t   alu1_id,
    input  wire commit_pkg::opcode_t    alu1_opcode,
    input  wire commit_pkg::pc_sel_t    alu1_pc_select,
    input  wire                         alu1_reg_write,
    input  wire                         alu1_mem_read,
    input  wire                         alu1_mem_write,
    input  wire                         alu1_taken,
    input  wire commit_pkg::addr_t      alu1_target,
    input  wire commit_pkg::data_t      alu1_store_data,
    input  wire                         alu2_valid,
    input  wire commit_pkg::rd_t        alu2_rd,
    input  wire commit_pkg::data_t      alu2_result,
    input  wire commit_pkg::inst_id_t   alu2_id,
    input  wire commit_pkg::opcode_t    alu2_opcode,
    input  wire commit_pkg::pc_sel_t    alu2_pc_select,
    input  wire                         alu2_reg_write,
    input  wire                         alu2_mem_read,
    input  wire                         alu2_mem_write,
    input  wire                         alu2_taken,
    input  wire commit_pkg::addr_t      alu2_target,
    input  wire commit_pkg::data_t      alu2_store_data,
    input  wire                         load_valid,
    input  wire commit_pkg::data_t      load_data,
    output logic                        mem_valid,
    output logic                        mem_read,
    output logic                        mem_write,
    output commit_pkg::addr_t           mem_address,
    output commit_pkg::data_t           mem_store_data,
    output logic                        commit_valid,
    output commit_pkg::inst_id_t        commit_id,
    output commit_pkg::rd_t             writeback_rd,
    output commit_pkg::data_t           writeback_data,
    output logic                        reg_write,
    output logic                        redirect_valid,
    output commit_pkg::pc_sel_t         pc_select,
    output commit_pkg::addr_t           redirect_target
);

    // selected item from the arbiter
    logic                   sel_valid;
    commit_pkg::rd_t        sel_rd;
    commit_pkg::data_t      sel_result;
    commit_pkg::inst_id_t   sel_id;
    commit_pkg::opcode_t    sel_opcode;
    commit_pkg::pc_sel_t    sel_pc_select;
    logic                   sel_reg_write;
    logic                   sel_mem_read;
    logic                   sel_mem_write;
    logic                   sel_taken;
    commit_pkg::addr_t      sel_target;
    commit_pkg::data_t      sel_store_data;

    // tracker to commit register
    logic                   alu_commit_valid;
    logic                   load_return_valid;
    commit_pkg::rd_t        load_return_rd;
    commit_pkg::inst_id_t   load_return_id;
    commit_pkg::data_t      load_return_data;
    logic                   load_taken;

    alu_arbiter u_alu_arbiter (.*);

    load_tracker u_load_tracker (.*);

    commit_register u_commit_register (.*);

endmodule

`default_nettype wire

//--- design/commit_register.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_settings.svh"

module commit_register (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         alu_commit_valid,
    input  wire commit_pkg::rd_t        sel_rd,
    input  wire commit_pkg::data_t      sel_result,
    input  wire commit_pkg::inst_id_t   sel_id,
    input  wire commit_pkg::opcode_t    sel_opcode,
    input  wire commit_pkg::pc_sel_t    sel_pc_select,
    input  wire                         sel_reg_write,
    input  wire                         sel_mem_write,
    input  wire                         sel_taken,
    input  wire commit_pkg::addr_t      sel_target,
    input  wire                         load_return_valid,
    input  wire commit_pkg::rd_t        load_return_rd,
    input  wire commit_pkg::inst_id_t   load_return_id,
    input  wire commit_pkg::data_t      load_return_data,
    output logic                        load_taken,
    output logic                        commit_valid,
    output commit_pkg::inst_id_t        commit_id,
    output commit_pkg::rd_t             writeback_rd,
    output commit_pkg::data_t           writeback_data,
    output logic                        reg_write,
    output logic                        redirect_valid,
    output commit_pkg::pc_sel_t         pc_select,
    output commit_pkg::addr_t           redirect_target
);

    logic is_jalr;
    logic is_taken_branch;
    logic is_redirect;
    logic item_reg_write;

    // an ALU or store item always wins over a returned load
    assign load_taken = load_return_valid && !alu_commit_valid;

    assign is_jalr         = sel_opcode == `COMMIT_OPCODE_JALR;
    assign is_taken_branch = (sel_opcode == `COMMIT_OPCODE_BRANCH) && sel_taken;
    assign is_redirect     = is_jalr || is_taken_branch;

    // stores never write the register file
    assign item_reg_write = sel_reg_write && !sel_mem_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid   <= 1'b0;
            reg_write      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= alu_commit_valid || load_taken;
            redirect_valid <= alu_commit_valid && is_redirect;
            if (alu_commit_valid) begin
                reg_write <= item_reg_write;
            end else begin
                reg_write <= load_taken;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alu_commit_valid) begin
            commit_id       <= sel_id;
            writeback_rd    <= sel_rd;
            writeback_data  <= sel_result;
            pc_select       <= sel_pc_select;
            redirect_target <= sel_target;
        end else if (load_taken) begin
            commit_id      <= load_return_id;
            writeback_rd   <= load_return_rd;
            writeback_data <= load_return_data;
        end
    end

endmodule

`default_nettype wire

//--- design/load_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module load_tracker (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         sel_valid,
    input  wire commit_pkg::rd_t        sel_rd,
    input  wire commit_pkg::data_t      sel_result,
    input  wire commit_pkg::inst_id_t   sel_id,
    input  wire                         sel_mem_read,
    input  wire                         sel_mem_write,
    input  wire commit_pkg::data_t      sel_store_data,
    input  wire                         load_valid,
    input  wire commit_pkg::data_t      load_data,
    input  wire                         load_taken,
    output logic                        mem_valid,
    output logic                        mem_read,
    output logic                        mem_write,
    output commit_pkg::addr_t           mem_address,
    output commit_pkg::data_t           mem_store_data,
    output logic                        alu_commit_valid,
    output logic                        load_return_valid,
    output commit_pkg::rd_t             load_return_rd,
    output commit_pkg::inst_id_t        load_return_id,
    output commit_pkg::data_t           load_return_data
);

    logic                   load_issue;
    logic                   load_pending;
    commit_pkg::rd_t        pending_rd;
    commit_pkg::inst_id_t   pending_id;
    logic                   return_held;
    logic                   return_capture;
    commit_pkg::data_t      return_data;

    // memory request goes out in the same cycle as the selection
    assign mem_read       = sel_valid && sel_mem_read;
    assign mem_write      = sel_valid && sel_mem_write;
    assign mem_valid      = mem_read || mem_write;
    assign mem_address    = commit_pkg::addr_t'(sel_result);
    assign mem_store_data = sel_store_data;

    assign load_issue       = mem_read;
    assign alu_commit_valid = sel_valid && !sel_mem_read;

    // returning data bypasses the return register when commit is free
    assign load_return_valid = return_held || load_valid;
    assign load_return_data  = return_held ? return_data : load_data;

    // rd and ID stay in the pending registers until the load commits
    assign load_return_rd    = pending_rd;
    assign load_return_id    = pending_id;

    assign return_capture = load_valid && (return_held || !load_taken);

    always_ff @(posedge clock) begin
        if (reset) begin
            load_pending <= 1'b0;
            return_held  <= 1'b0;
        end else begin
            if (load_issue) begin
                load_pending <= 1'b1;
            end else if (load_valid) begin
                load_pending <= 1'b0;
            end
            if (return_capture) begin
                return_held <= 1'b1;
            end else if (load_taken) begin
                return_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_issue) begin
            pending_rd <= sel_rd;
            pending_id <= sel_id;
        end
        if (return_capture) begin
            return_data <= load_data;
        end
    end

    single_outstanding_load: assert property (@(posedge clock) disable iff (reset)
        load_issue |-> !load_pending)
        else $error("second load issued while one is outstanding");

    load_data_only_when_pending: assert property (@(posedge clock) disable iff (reset)
        load_valid |-> load_pending)
        else $error("load_valid with no outstanding load");

endmodule

`default_nettype wire

//--- design/alu_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module alu_arbiter (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         alu1_valid,
    input  wire commit_pkg::rd_t        alu1_rd,
    input  wire commit_pkg::data_t      alu1_result,
    input  wire commit_pkg::inst_id_t   alu1_id,
    input  wire commit_pkg::opcode_t    alu1_opcode,
    input  wire commit_pkg::pc_sel_t    alu1_pc_select,
    input  wire                         alu1_reg_write,
    input  wire                         alu1_mem_read,
    input  wire                         alu1_mem_write,
    input  wire                         alu1_taken,
    input  wire commit_pkg::addr_t      alu1_target,
    input  wire commit_pkg::data_t      alu1_store_data,
    input  wire                         alu2_valid,
    input  wire commit_pkg::rd_t        alu2_rd,
    input  wire commit_pkg::data_t      alu2_result,
    input  wire commit_pkg::inst_id_t   alu2_id,
    input  wire commit_pkg::opcode_t    alu2_opcode,
    input  wire commit_pkg::pc_sel_t    alu2_pc_select,
    input  wire                         alu2_reg_write,
    input  wire                         alu2_mem_read,
    input  wire                         alu2_mem_write,
    input  wire                         alu2_taken,
    input  wire commit_pkg::addr_t      alu2_target,
    input  wire commit_pkg::data_t      alu2_store_data,
    output logic                        sel_valid,
    output commit_pkg::rd_t             sel_rd,
    output commit_pkg::data_t           sel_result,
    output commit_pkg::inst_id_t        sel_id,
    output commit_pkg::opcode_t         sel_opcode,
    output commit_pkg::pc_sel_t         sel_pc_select,
    output logic                        sel_reg_write,
    output logic                        sel_mem_read,
    output logic                        sel_mem_write,
    output logic                        sel_taken,
    output commit_pkg::addr_t           sel_target,
    output commit_pkg::data_t           sel_store_data
);

    // one-entry hold for ALU2 when both ALUs finish together
    logic                   hold_valid;
    commit_pkg::rd_t        hold_rd;
    commit_pkg::data_t      hold_result;
    commit_pkg::inst_id_t   hold_id;
    commit_pkg::opcode_t    hold_opcode;
    commit_pkg::pc_sel_t    hold_pc_select;
    logic                   hold_reg_write;
    logic                   hold_mem_read;
    logic                   hold_mem_write;
    logic                   hold_taken;
    commit_pkg::addr_t      hold_target;
    commit_pkg::data_t      hold_store_data;
    logic                   both_valid;
    logic                   hold_select;

    assign both_valid  = alu1_valid && alu2_valid;
    assign hold_select = hold_valid && !alu1_valid && !alu2_valid;
    assign sel_valid   = alu1_valid || alu2_valid || hold_valid;

    // ALU1 first, then ALU2, then the held entry
    always_comb begin
        if (alu1_valid) begin
            sel_rd         = alu1_rd;
            sel_result     = alu1_result;
            sel_id         = alu1_id;
            sel_opcode     = alu1_opcode;
            sel_pc_select  = alu1_pc_select;
            sel_reg_write  = alu1_reg_write;
            sel_mem_read   = alu1_mem_read;
            sel_mem_write  = alu1_mem_write;
            sel_taken      = alu1_taken;
            sel_target     = alu1_target;
            sel_store_data = alu1_store_data;
        end else if (alu2_valid) begin
            sel_rd         = alu2_rd;
            sel_result     = alu2_result;
            sel_id         = alu2_id;
            sel_opcode     = alu2_opcode;
            sel_pc_select  = alu2_pc_select;
            sel_reg_write  = alu2_reg_write;
            sel_mem_read   = alu2_mem_read;
            sel_mem_write  = alu2_mem_write;
            sel_taken      = alu2_taken;
            sel_target     = alu2_target;
            sel_store_data = alu2_store_data;
        end else begin
            sel_rd         = hold_rd;
            sel_result     = hold_result;
            sel_id         = hold_id;
            sel_opcode     = hold_opcode;
            sel_pc_select  = hold_pc_select;
            sel_reg_write  = hold_reg_write;
            sel_mem_read   = hold_mem_read;
            sel_mem_write  = hold_mem_write;
            sel_taken      = hold_taken;
            sel_target     = hold_target;
            sel_store_data = hold_store_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (both_valid) begin
            hold_valid <= 1'b1;
        end else if (hold_select) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (both_valid) begin
            hold_rd         <= alu2_rd;
            hold_result     <= alu2_result;
            hold_id         <= alu2_id;
            hold_opcode     <= alu2_opcode;
            hold_pc_select  <= alu2_pc_select;
            hold_reg_write  <= alu2_reg_write;
            hold_mem_read   <= alu2_mem_read;
            hold_mem_write  <= alu2_mem_write;
            hold_taken      <= alu2_taken;
            hold_target     <= alu2_target;
            hold_store_data <= alu2_store_data;
        end
    end

    // the held entry needs a free cycle, or it would be lost
    no_result_while_held: assert property (@(posedge clock) disable iff (reset)
        hold_valid |-> !(alu1_valid || alu2_valid))
        else $error("ALU result arrived while the ALU2 hold entry was full");

endmodule

`default_nettype wire

//--- design/commit_pkg.sv
`default_nettype none

`include "commit_settings.svh"

package commit_pkg;

    // result, load data and store data
    typedef logic [`COMMIT_DATA_WIDTH-1:0] data_t;

    // memory address or PC target
    typedef logic [`COMMIT_ADDRESS_BITS-1:0] addr_t;

    // destination register index
    typedef logic [`COMMIT_RD_BITS-1:0] rd_t;

    typedef logic [`COMMIT_ID_BITS-1:0] inst_id_t;

    typedef logic [6:0] opcode_t;

    // next-PC select code, passed on to fetch with a redirect
    typedef logic [1:0] pc_sel_t;

endpackage

`default_nettype wire

//--- design/commit_settings.svh
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// datapath widths
`define COMMIT_DATA_WIDTH 32
`define COMMIT_ADDRESS_BITS 20
`define COMMIT_RD_BITS 5

// two instructions in flight, so a 2-bit ID is enough
`define COMMIT_ID_BITS 2

// opcodes that can redirect the PC at commit
`define COMMIT_OPCODE_JALR 7'b1100111
`define COMMIT_OPCODE_BRANCH 7'b1100011

`endif
